/* sc_pkg.sv */
// Shared widths, APB register map and packed structs
// for the scan converter output path
package sc_pkg;

    localparam int PIX_W   = 8;
    localparam int POS_W   = 12;
    // Threshold step per scanline strength level
    localparam int SL_STEP = 16;

    // APB register map, byte addresses
    localparam logic [7:0] REG_H_TIMING = 8'h00;
    localparam logic [7:0] REG_V_TIMING = 8'h04;
    localparam logic [7:0] REG_PORCH    = 8'h08;
    localparam logic [7:0] REG_WIN_X    = 8'h0C;
    localparam logic [7:0] REG_WIN_Y    = 8'h10;
    localparam logic [7:0] REG_SL       = 8'h14;
    localparam logic [7:0] REG_MISC     = 8'h18;

    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } rgb_t;

    // Sync outputs are active low
    typedef struct packed {
        logic             hsync;
        logic             vsync;
        logic             de;
        logic [POS_W-1:0] xpos;
        logic [POS_W-1:0] ypos;
    } beam_t;

    typedef struct packed {
        beam_t beam;
        rgb_t  rgb;
    } pix_beat_t;

    typedef struct packed {
        logic [POS_W-1:0] h_total;
        logic [POS_W-1:0] h_active;
        logic [7:0]       h_synclen;
        logic [8:0]       h_backporch;
        logic [POS_W-1:0] v_total;
        logic [POS_W-1:0] v_active;
        logic [3:0]       v_synclen;
        logic [8:0]       v_backporch;
    } timing_cfg_t;

    // sl_iv is the last phase before wrap, one overlay bit and strength per phase
    typedef struct packed {
        logic [1:0]      sl_iv;
        logic [3:0]      sl_overlay;
        logic [3:0][3:0] sl_str;
    } sl_cfg_t;

    typedef struct packed {
        logic [POS_W-1:0] x_start;
        logic [POS_W-1:0] x_size;
        logic [POS_W-1:0] y_start;
        logic [POS_W-1:0] y_size;
        logic [3:0]       mask_br;
        logic [2:0]       mask_color;
        logic             tp_enable;
    } out_cfg_t;

endpackage

/* sc_cfg_regs.sv */
// APB configuration slave with timing, scanline and output window registers
module sc_cfg_regs
    import sc_pkg::*;
(
    input  logic        PCLK_OUT_i,
    input  logic        rst_n_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output timing_cfg_t timing_cfg_o,
    output sl_cfg_t     sl_cfg_o,
    output out_cfg_t    out_cfg_o
);

    // 40x20 frame with a 28x14 active area
    localparam timing_cfg_t TIMING_DEF = '{
        h_total: 12'd40, h_active: 12'd28, h_synclen: 8'd4, h_backporch: 9'd6,
        v_total: 12'd20, v_active: 12'd14, v_synclen: 4'd2, v_backporch: 9'd2
    };
    localparam sl_cfg_t SL_DEF = '0;
    // Window open over the full position range
    localparam out_cfg_t OUT_DEF = '{
        x_start: '0, x_size: 12'hFFF, y_start: '0, y_size: 12'hFFF,
        mask_br: '0, mask_color: '0, tp_enable: 1'b0
    };

    timing_cfg_t timing_q;
    sl_cfg_t     sl_q;
    out_cfg_t    out_q;
    logic        addr_ok;
    logic        wr_en;

    always_comb begin
        case (paddr_i)
            REG_H_TIMING, REG_V_TIMING, REG_PORCH, REG_WIN_X,
            REG_WIN_Y, REG_SL, REG_MISC: addr_ok = 1'b1;
            default:                     addr_ok = 1'b0;
        endcase
    end

    // Zero wait states, error only in the access phase
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i & penable_i & ~addr_ok;
    assign wr_en     = psel_i & penable_i & pwrite_i & addr_ok;

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            timing_q <= TIMING_DEF;
            sl_q     <= SL_DEF;
            out_q    <= OUT_DEF;
        end else if (wr_en) begin
            case (paddr_i)
                REG_H_TIMING: begin
                    timing_q.h_total   <= pwdata_i[11:0];
                    timing_q.h_active  <= pwdata_i[23:12];
                    timing_q.h_synclen <= pwdata_i[31:24];
                end
                REG_V_TIMING: begin
                    timing_q.v_total   <= pwdata_i[11:0];
                    timing_q.v_active  <= pwdata_i[23:12];
                    timing_q.v_synclen <= pwdata_i[27:24];
                end
                REG_PORCH: begin
                    timing_q.h_backporch <= pwdata_i[8:0];
                    timing_q.v_backporch <= pwdata_i[24:16];
                end
                REG_WIN_X: begin
                    out_q.x_start <= pwdata_i[11:0];
                    out_q.x_size  <= pwdata_i[27:16];
                end
                REG_WIN_Y: begin
                    out_q.y_start <= pwdata_i[11:0];
                    out_q.y_size  <= pwdata_i[27:16];
                end
                REG_SL: begin
                    sl_q.sl_str     <= pwdata_i[15:0];
                    sl_q.sl_overlay <= pwdata_i[19:16];
                    sl_q.sl_iv      <= pwdata_i[21:20];
                end
                default: begin
                    out_q.mask_br    <= pwdata_i[3:0];
                    out_q.mask_color <= pwdata_i[6:4];
                    out_q.tp_enable  <= pwdata_i[7];
                end
            endcase
        end
    end

    // Readback uses the same bit layout as the writes
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                REG_H_TIMING: prdata_o = {timing_q.h_synclen, timing_q.h_active, timing_q.h_total};
                REG_V_TIMING: prdata_o = {4'h0, timing_q.v_synclen, timing_q.v_active,
                                          timing_q.v_total};
                REG_PORCH:    prdata_o = {7'h0, timing_q.v_backporch, 7'h0, timing_q.h_backporch};
                REG_WIN_X:    prdata_o = {4'h0, out_q.x_size, 4'h0, out_q.x_start};
                REG_WIN_Y:    prdata_o = {4'h0, out_q.y_size, 4'h0, out_q.y_start};
                REG_SL:       prdata_o = {10'h0, sl_q.sl_iv, sl_q.sl_overlay, sl_q.sl_str};
                REG_MISC:     prdata_o = {24'h0, out_q.tp_enable, out_q.mask_color, out_q.mask_br};
                default:      prdata_o = '0;
            endcase
        end
    end

    assign timing_cfg_o = timing_q;
    assign sl_cfg_o     = sl_q;
    assign out_cfg_o    = out_q;

endmodule

/* sc_timing_gen.sv */
// Horizontal and vertical counters producing sync, data enable,
// active positions and the scanline phase
module sc_timing_gen
    import sc_pkg::*;
#(
    parameter int TIMING_W  = 12,
    parameter int SL_PHASES = 4
) (
    input  logic                         PCLK_OUT_i,
    input  logic                         rst_n_i,
    input  timing_cfg_t                  timing_cfg_i,
    input  logic [$clog2(SL_PHASES)-1:0] sl_iv_i,
    output beam_t                        beam_o,
    output logic [$clog2(SL_PHASES)-1:0] sl_phase_o
);

    localparam int PH_W = $clog2(SL_PHASES);

    typedef logic [TIMING_W-1:0] cnt_t;
    // One extra bit so start + active never overflows
    typedef logic [TIMING_W:0]   ext_t;

    cnt_t            h_cnt;
    cnt_t            v_cnt;
    cnt_t            v_next;
    logic [PH_W-1:0] ph_cnt;
    ext_t            h_start;
    ext_t            h_end;
    ext_t            v_start;
    ext_t            v_end;
    logic            h_wrap;
    logic            v_wrap;
    logic            h_act;
    logic            v_act;

    assign h_start = ext_t'(timing_cfg_i.h_synclen) + ext_t'(timing_cfg_i.h_backporch);
    assign h_end   = h_start + ext_t'(timing_cfg_i.h_active);
    assign v_start = ext_t'(timing_cfg_i.v_synclen) + ext_t'(timing_cfg_i.v_backporch);
    assign v_end   = v_start + ext_t'(timing_cfg_i.v_active);

    assign h_wrap = (h_cnt == cnt_t'(timing_cfg_i.h_total - 1'b1));
    assign v_wrap = (v_cnt == cnt_t'(timing_cfg_i.v_total - 1'b1));
    assign v_next = v_wrap ? '0 : v_cnt + 1'b1;

    assign h_act = (ext_t'(h_cnt) >= h_start) && (ext_t'(h_cnt) < h_end);
    assign v_act = (ext_t'(v_cnt) >= v_start) && (ext_t'(v_cnt) < v_end);

    // Counters, with the line phase tracking v_cnt
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            ph_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
            v_cnt <= v_next;
            if (ext_t'(v_next) == v_start) begin
                // First active line restarts the phase
                ph_cnt <= '0;
            end else if (v_act) begin
                ph_cnt <= (ph_cnt == sl_iv_i) ? '0 : ph_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Registered beam, one cycle behind the counters
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beam_o.hsync <= 1'b1;
            beam_o.vsync <= 1'b1;
            beam_o.de    <= 1'b0;
            beam_o.xpos  <= '0;
            beam_o.ypos  <= '0;
            sl_phase_o   <= '0;
        end else begin
            beam_o.hsync <= (h_cnt >= cnt_t'(timing_cfg_i.h_synclen));
            beam_o.vsync <= (v_cnt >= cnt_t'(timing_cfg_i.v_synclen));
            beam_o.de    <= h_act & v_act;
            beam_o.xpos  <= h_act ? POS_W'(ext_t'(h_cnt) - h_start) : '0;
            beam_o.ypos  <= v_act ? POS_W'(ext_t'(v_cnt) - v_start) : '0;
            sl_phase_o   <= ph_cnt;
        end
    end

endmodule

/* sc_scanline.sv */
// Three-stage scanline darkening of the external source pixel
// using a saturating threshold subtraction
module sc_scanline
    import sc_pkg::*;
(
    input  logic      PCLK_OUT_i,
    input  logic      rst_n_i,
    input  beam_t     beam_i,
    input  logic [1:0] sl_phase_i,
    input  rgb_t      rgb_i,
    input  sl_cfg_t   sl_cfg_i,
    output pix_beat_t beat_o
);

    pix_beat_t        beat1_q;
    pix_beat_t        beat2_q;
    pix_beat_t        beat3_q;
    logic             draw1_q;
    logic             draw2_q;
    logic [3:0]       str1_q;
    logic [PIX_W-1:0] thold2_q;

    function automatic logic [PIX_W-1:0] sat_sub(input logic [PIX_W-1:0] ch,
                                                 input logic [PIX_W-1:0] t);
        return (ch > t) ? ch - t : '0;
    endfunction

    // Stage 1: source select and per-phase overlay lookup
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat1_q      <= '0;
            beat1_q.beam.hsync <= 1'b1;
            beat1_q.beam.vsync <= 1'b1;
            draw1_q      <= 1'b0;
            str1_q       <= '0;
        end else begin
            beat1_q.beam <= beam_i;
            beat1_q.rgb  <= rgb_i;
            draw1_q      <= sl_cfg_i.sl_overlay[sl_phase_i];
            str1_q       <= sl_cfg_i.sl_str[sl_phase_i];
        end
    end

    // Stage 2: threshold (s+1)*STEP-1
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat2_q  <= '0;
            beat2_q.beam.hsync <= 1'b1;
            beat2_q.beam.vsync <= 1'b1;
            draw2_q  <= 1'b0;
            thold2_q <= '0;
        end else begin
            beat2_q  <= beat1_q;
            draw2_q  <= draw1_q;
            thold2_q <= PIX_W'((int'(str1_q) + 1) * SL_STEP - 1);
        end
    end

    // Stage 3: subtract on drawn lines, clamp at black
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat3_q <= '0;
            beat3_q.beam.hsync <= 1'b1;
            beat3_q.beam.vsync <= 1'b1;
        end else begin
            beat3_q.beam  <= beat2_q.beam;
            beat3_q.rgb.r <= draw2_q ? sat_sub(beat2_q.rgb.r, thold2_q) : beat2_q.rgb.r;
            beat3_q.rgb.g <= draw2_q ? sat_sub(beat2_q.rgb.g, thold2_q) : beat2_q.rgb.g;
            beat3_q.rgb.b <= draw2_q ? sat_sub(beat2_q.rgb.b, thold2_q) : beat2_q.rgb.b;
        end
    end

    assign beat_o = beat3_q;

endmodule

/* sc_border_tp.sv */
// Output stage with window mask colour, XOR test pattern
// and the registered video outputs
module sc_border_tp
    import sc_pkg::*;
(
    input  logic             PCLK_OUT_i,
    input  logic             rst_n_i,
    input  pix_beat_t        beat_i,
    input  out_cfg_t         out_cfg_i,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o,
    output logic [POS_W-1:0] xpos_o,
    output logic [POS_W-1:0] ypos_o,
    output rgb_t             rgb_o
);

    logic [POS_W:0]   x_end;
    logic [POS_W:0]   y_end;
    logic             in_win;
    logic [PIX_W-1:0] tp_val;
    logic [PIX_W-1:0] mask_lvl;
    rgb_t             mask_rgb;
    rgb_t             pix_nxt;
    beam_t            beam_q;
    rgb_t             rgb_q;

    assign x_end  = {1'b0, out_cfg_i.x_start} + {1'b0, out_cfg_i.x_size};
    assign y_end  = {1'b0, out_cfg_i.y_start} + {1'b0, out_cfg_i.y_size};
    assign in_win = (beat_i.beam.xpos >= out_cfg_i.x_start) && ({1'b0, beat_i.beam.xpos} < x_end) &&
                    (beat_i.beam.ypos >= out_cfg_i.y_start) && ({1'b0, beat_i.beam.ypos} < y_end);

    assign tp_val   = PIX_W'(beat_i.beam.xpos ^ beat_i.beam.ypos);
    // Brightness nibble repeated to fill the channel
    assign mask_lvl = {2{out_cfg_i.mask_br}};
    assign mask_rgb = '{r: out_cfg_i.mask_color[2] ? mask_lvl : '0,
                        g: out_cfg_i.mask_color[1] ? mask_lvl : '0,
                        b: out_cfg_i.mask_color[0] ? mask_lvl : '0};

    assign pix_nxt = out_cfg_i.tp_enable ? '{r: tp_val, g: tp_val, b: tp_val} :
                     in_win              ? beat_i.rgb : mask_rgb;

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beam_q <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, xpos: '0, ypos: '0};
            rgb_q  <= '0;
        end else begin
            beam_q <= beat_i.beam;
            rgb_q  <= pix_nxt;
        end
    end

    assign hsync_o = beam_q.hsync;
    assign vsync_o = beam_q.vsync;
    assign de_o    = beam_q.de;
    assign xpos_o  = beam_q.xpos;
    assign ypos_o  = beam_q.ypos;
    assign rgb_o   = rgb_q;

endmodule

/* sc_top.sv */
// Scan converter output path: APB configuration, timing generator,
// scanline processing and the masked output stage
module sc_top
    import sc_pkg::*;
#(
    parameter int TIMING_W  = 12,
    parameter int SL_PHASES = 4
) (
    input  logic             PCLK_OUT_i,
    input  logic             rst_n_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [7:0]       paddr_i,
    input  logic [31:0]      pwdata_i,
    input  rgb_t             rgb_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o,
    output logic [POS_W-1:0] xpos_o,
    output logic [POS_W-1:0] ypos_o,
    output rgb_t             rgb_o
);

    timing_cfg_t                  timing_cfg;
    sl_cfg_t                      sl_cfg;
    out_cfg_t                     out_cfg;
    beam_t                        beam;
    logic [$clog2(SL_PHASES)-1:0] sl_phase;
    pix_beat_t                    beat;

    sc_cfg_regs u_cfg_regs (
        .PCLK_OUT_i   (PCLK_OUT_i),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .timing_cfg_o (timing_cfg),
        .sl_cfg_o     (sl_cfg),
        .out_cfg_o    (out_cfg)
    );

    sc_timing_gen #(
        .TIMING_W  (TIMING_W),
        .SL_PHASES (SL_PHASES)
    ) u_timing_gen (
        .PCLK_OUT_i   (PCLK_OUT_i),
        .rst_n_i      (rst_n_i),
        .timing_cfg_i (timing_cfg),
        .sl_iv_i      (sl_cfg.sl_iv),
        .beam_o       (beam),
        .sl_phase_o   (sl_phase)
    );

    sc_scanline u_scanline (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .beam_i     (beam),
        .sl_phase_i (sl_phase),
        .rgb_i      (rgb_i),
        .sl_cfg_i   (sl_cfg),
        .beat_o     (beat)
    );

    sc_border_tp u_border_tp (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .beat_i     (beat),
        .out_cfg_i  (out_cfg),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .de_o       (de_o),
        .xpos_o     (xpos_o),
        .ypos_o     (ypos_o),
        .rgb_o      (rgb_o)
    );

endmodule

/* sc_tb.sv */
// Table-driven testbench for the scan converter output path
// with an APB driver and a pixel reference model
module sc_tb
    import sc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS      = 4;
    localparam int APB_TIMEOUT   = 16;
    localparam int FRAME_TIMEOUT = 12000;

    logic        PCLK_OUT_i;
    logic        rst_n_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [7:0]  paddr_i;
    logic [31:0] pwdata_i;
    logic [23:0] rgb_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        de_o;
    logic [11:0] xpos_o;
    logic [11:0] ypos_o;
    logic [23:0] rgb_o;

    // Register words per row in address order 0x00 to 0x18
    logic [31:0] reg_tab [NUM_ROWS][7];
    // Row expects some pixels outside the window
    bit          mask_tab [NUM_ROWS];
    logic [23:0] src_rgb;
    logic [31:0] rng_state;
    int          err_cnt;
    int          chk_cnt;

    sc_top uut (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .rgb_i      (rgb_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .de_o       (de_o),
        .xpos_o     (xpos_o),
        .ypos_o     (ypos_o),
        .rgb_o      (rgb_o)
    );

    always #20 PCLK_OUT_i = ~PCLK_OUT_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] darken(input logic [7:0] ch, input int s);
        int t;
        t = (s + 1) * 16 - 1;
        return (int'(ch) > t) ? 8'(int'(ch) - t) : 8'd0;
    endfunction

    function automatic bit outside_window(input int row, input int x, input int y);
        int xs;
        int xw;
        int ys;
        int yw;
        xs = reg_tab[row][3][11:0];
        xw = reg_tab[row][3][27:16];
        ys = reg_tab[row][4][11:0];
        yw = reg_tab[row][4][27:16];
        return (x < xs) || (x >= xs + xw) || (y < ys) || (y >= ys + yw);
    endfunction

    // Expected output pixel for an active position
    function automatic logic [23:0] model_pixel(input int row, input int x, input int y,
                                                input logic [23:0] src);
        logic [31:0] sl;
        logic [31:0] misc;
        logic [7:0]  lvl;
        int          ph;
        int          s;
        sl   = reg_tab[row][5];
        misc = reg_tab[row][6];
        if (misc[7]) begin
            return {3{8'(x ^ y)}};
        end
        if (outside_window(row, x, y)) begin
            lvl = {2{misc[3:0]}};
            return {misc[6] ? lvl : 8'd0, misc[5] ? lvl : 8'd0, misc[4] ? lvl : 8'd0};
        end
        ph = y % (int'(sl[21:20]) + 1);
        if (!sl[16 + ph]) begin
            return src;
        end
        s = (sl >> (4 * ph)) & 15;
        return {darken(src[23:16], s), darken(src[15:8], s), darken(src[7:0], s)};
    endfunction

    task automatic add_row(input int idx, input int ht, input int ha, input int hs,
                           input int hbp, input int vt, input int va, input int vs,
                           input int vbp, input logic [31:0] win_x, input logic [31:0] win_y,
                           input logic [31:0] sl, input logic [31:0] misc, input bit masked);
        reg_tab[idx][0] = {8'(hs), 12'(ha), 12'(ht)};
        reg_tab[idx][1] = {4'h0, 4'(vs), 12'(va), 12'(vt)};
        reg_tab[idx][2] = {7'h0, 9'(vbp), 7'h0, 9'(hbp)};
        reg_tab[idx][3] = win_x;
        reg_tab[idx][4] = win_y;
        reg_tab[idx][5] = sl;
        reg_tab[idx][6] = misc;
        mask_tab[idx]   = masked;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        $display("Errors found");
        $finish;
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge PCLK_OUT_i);
        #2;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge PCLK_OUT_i);
        #2;
        penable_i = 1'b1;
        @(negedge PCLK_OUT_i);
        while (!pready_o && waits < APB_TIMEOUT) begin
            @(negedge PCLK_OUT_i);
            waits++;
        end
        if (!pready_o) begin
            abort_run("pready_o stayed low in the APB access phase");
        end
        check_val("APB wait states", 0, waits);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge PCLK_OUT_i);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_val($sformatf("pslverr_o write 0x%0h", addr), 0, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic check_reset_state();
        check_val("hsync_o", 1, hsync_o);
        check_val("vsync_o", 1, vsync_o);
        check_val("de_o", 0, de_o);
        check_val("rgb_o", 0, rgb_o);
    endtask

    // Leaves the run on the sample where vsync_o has just gone low
    task automatic wait_vsync_fall();
        int   waits;
        logic prev;
        waits = 0;
        @(negedge PCLK_OUT_i);
        prev = vsync_o;
        @(negedge PCLK_OUT_i);
        while (!(prev && !vsync_o) && waits < FRAME_TIMEOUT) begin
            prev = vsync_o;
            @(negedge PCLK_OUT_i);
            waits++;
        end
        if (!(prev && !vsync_o)) begin
            abort_run("no falling edge on vsync_o");
        end
    endtask

    task automatic check_frame(input int row);
        int ht;
        int ha;
        int hs;
        int vt;
        int va;
        int vs;
        int line;
        int pix;
        int de_cnt;
        int hs_cnt;
        int vs_cnt;
        int act_lines;
        int mask_cnt;
        ht        = reg_tab[row][0][11:0];
        ha        = reg_tab[row][0][23:12];
        hs        = reg_tab[row][0][31:24];
        vt        = reg_tab[row][1][11:0];
        va        = reg_tab[row][1][23:12];
        vs        = reg_tab[row][1][27:24];
        act_lines = 0;
        mask_cnt  = 0;
        vs_cnt    = 0;
        for (line = 0; line < vt; line++) begin
            de_cnt = 0;
            hs_cnt = 0;
            for (pix = 0; pix < ht; pix++) begin
                if (!hsync_o) hs_cnt++;
                if (!vsync_o) vs_cnt++;
                if (de_o) begin
                    check_val("xpos_o", de_cnt, xpos_o);
                    check_val("ypos_o", act_lines, ypos_o);
                    check_val("rgb_o", model_pixel(row, de_cnt, act_lines, src_rgb), rgb_o);
                    if (!reg_tab[row][6][7] && outside_window(row, de_cnt, act_lines)) begin
                        mask_cnt++;
                    end
                    de_cnt++;
                end
                @(negedge PCLK_OUT_i);
            end
            check_val("hsync_o low cycles", hs, hs_cnt);
            if (de_cnt != 0) begin
                check_val("de_o cycles per line", ha, de_cnt);
                act_lines++;
            end
        end
        // Sync lines at the top of the frame
        check_val("vsync_o low cycles", vs * ht, vs_cnt);
        check_val("active lines per frame", va, act_lines);
        check_val("masked pixels present", mask_tab[row], mask_cnt != 0);
    endtask

    initial begin : run_tests
        int          row;
        int          i;
        logic [31:0] rdata;
        logic        err;
        PCLK_OUT_i = 1'b0;
        rst_n_i    = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        rgb_i      = '0;
        err_cnt    = 0;
        chk_cnt    = 0;
        rng_state  = 32'd36572;

        // Full window with scanlines, partial window, test pattern, narrow window
        add_row(0, 40, 28, 4, 6, 20, 14, 2, 2, 32'h0FFF_0000, 32'h0FFF_0000,
                32'h0012_0030, 32'h0000_0000, 1'b0);
        add_row(1, 48, 32, 5, 8, 22, 16, 3, 2, 32'h0014_0004, 32'h0009_0003,
                32'h003A_F972, 32'h0000_005A, 1'b1);
        add_row(2, 44, 30, 4, 6, 18, 12, 2, 2, 32'h0FFF_0000, 32'h0FFF_0000,
                32'h0001_0004, 32'h0000_00F5, 1'b0);
        add_row(3, 40, 24, 6, 5, 20, 10, 3, 4, 32'h000A_0000, 32'h0064_0005,
                32'h0025_0C00, 32'h0000_0023, 1'b1);

        // Reset held over two rising edges
        @(posedge PCLK_OUT_i);
        @(negedge PCLK_OUT_i);
        check_reset_state();
        @(posedge PCLK_OUT_i);
        #2;
        rst_n_i = 1'b1;
        @(posedge PCLK_OUT_i);
        @(negedge PCLK_OUT_i);
        check_reset_state();

        for (row = 0; row < NUM_ROWS; row++) begin
            rng_state = xorshift32(rng_state);
            src_rgb   = rng_state[23:0];
            @(posedge PCLK_OUT_i);
            #2;
            rgb_i = src_rgb;
            for (i = 0; i < 7; i++) begin
                apb_write(8'(4 * i), reg_tab[row][i]);
            end
            for (i = 0; i < 7; i++) begin
                apb_read(8'(4 * i), rdata, err);
                check_val($sformatf("prdata_o at 0x%0h", 4 * i), reg_tab[row][i], rdata);
                check_val("pslverr_o on read", 0, err);
            end
            apb_read(8'h40, rdata, err);
            check_val("pslverr_o at 0x40", 1, err);
            wait_vsync_fall();
            check_frame(row);
        end

        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sc_top.f */
sc_pkg.sv
sc_cfg_regs.sv
sc_timing_gen.sv
sc_scanline.sv
sc_border_tp.sv
sc_top.sv
sc_tb.sv

/* Bender.yml */
package:
  name: sc_top

sources:
  - sc_pkg.sv
  - sc_cfg_regs.sv
  - sc_timing_gen.sv
  - sc_scanline.sv
  - sc_border_tp.sv
  - sc_top.sv
  - target: simulation
    files:
      - sc_tb.sv
